//--- include/tseq_defs.svh
// ==============================
// test sequencer sizes, register
// addresses and poll wait length
// ==============================
`ifndef TSEQ_DEFS_SVH
`define TSEQ_DEFS_SVH

// byte address of the first window word
`define TSEQ_MEM_BASE     16'h1000
// words filled and read back
`define TSEQ_FILL_WORDS   64
// a write here starts the peripheral
`define TSEQ_REG_GO       16'h0000
// bit 0 set when the peripheral is idle
`define TSEQ_REG_STATUS   16'h0008
`define TSEQ_WAIT_CYCLES  16

`endif

//--- source/tseq_pkg.sv
// ==============================
// shared types of the test sequencer
// words, addresses, microinstruction
// and the opcode / register enums
// ==============================
`default_nettype none

package tseq_pkg;

   typedef logic [31:0] word_t;   // data word
   typedef logic [15:0] paddr_t;  // apb byte address
   typedef logic [7:0]  uaddr_t;  // microcode address

   // opcode[47:44] dst[43:41] src[40:38] target[37:32] imm[31:0]
   typedef logic [47:0] uinst_t;

   typedef enum logic [3:0] {
      OP_NOP   = 4'd0,
      OP_WRITE = 4'd1,
      OP_READ  = 4'd2,
      OP_ADD   = 4'd3,   // dst = src + imm
      OP_SUB   = 4'd4,   // dst = src - imm
      OP_TST   = 4'd5,   // branch if (dst & src) == 0
      OP_CMP   = 4'd6,   // branch if dst == src
      OP_JMP   = 4'd7,
      OP_DONE  = 4'd8,
      OP_WAIT  = 4'd9,
      OP_FAULT = 4'd15
   } opcode_e;

   typedef enum logic [2:0] {
      R_NONE = 3'd0,
      R_A    = 3'd1,   // bus address
      R_B    = 3'd2,   // loop count
      R_C    = 3'd3,
      R_D    = 3'd4,   // bus data
      R_I    = 3'd5,   // immediate
      R_P    = 3'd7    // expected pattern for a
   } reg_sel_e;

endpackage

`default_nettype wire

//--- source/tseq_urom.sv
// ==============================
// microcode ROM, registered output
// fill, start, poll and compare program
// ==============================
`timescale 1ns/100ps
`default_nettype none
`include "tseq_defs.svh"

module tseq_urom (
   input  logic             clk,
   input  logic             reset,
   input  tseq_pkg::uaddr_t fetch_addr,
   output tseq_pkg::uinst_t uinst
);

   function automatic tseq_pkg::uinst_t ui(input tseq_pkg::opcode_e  op,
                                           input tseq_pkg::reg_sel_e dsel,
                                           input tseq_pkg::reg_sel_e ssel,
                                           input logic [5:0]         target,
                                           input tseq_pkg::word_t    imm);
      return {op, dsel, ssel, target, imm};
   endfunction

   always_ff @(posedge clk)
   begin
      if (reset)
         uinst <= ui(tseq_pkg::OP_NOP, tseq_pkg::R_NONE, tseq_pkg::R_NONE, 6'h00, '0);
      else
         case (fetch_addr)
            // fill the window with the address pattern
            8'h00: uinst <= ui(tseq_pkg::OP_ADD, tseq_pkg::R_A, tseq_pkg::R_NONE,
                               6'h00, 32'(`TSEQ_MEM_BASE));       // a = base
            8'h01: uinst <= ui(tseq_pkg::OP_ADD, tseq_pkg::R_B, tseq_pkg::R_NONE,
                               6'h00, 32'h0);                     // b = 0
            8'h02: uinst <= ui(tseq_pkg::OP_ADD, tseq_pkg::R_D, tseq_pkg::R_P,
                               6'h00, 32'h0);                     // d = pattern(a)
            8'h03: uinst <= ui(tseq_pkg::OP_WRITE, tseq_pkg::R_NONE, tseq_pkg::R_NONE,
                               6'h00, 32'h0);
            8'h04: uinst <= ui(tseq_pkg::OP_ADD, tseq_pkg::R_A, tseq_pkg::R_A,
                               6'h00, 32'h4);                     // next word
            8'h05: uinst <= ui(tseq_pkg::OP_ADD, tseq_pkg::R_B, tseq_pkg::R_B,
                               6'h00, 32'h1);
            8'h06: uinst <= ui(tseq_pkg::OP_CMP, tseq_pkg::R_B, tseq_pkg::R_I,
                               6'h08, 32'(`TSEQ_FILL_WORDS));
            8'h07: uinst <= ui(tseq_pkg::OP_JMP, tseq_pkg::R_NONE, tseq_pkg::R_NONE,
                               6'h02, 32'h0);
            // kick the peripheral
            8'h08: uinst <= ui(tseq_pkg::OP_ADD, tseq_pkg::R_A, tseq_pkg::R_NONE,
                               6'h00, 32'(`TSEQ_REG_GO));
            8'h09: uinst <= ui(tseq_pkg::OP_ADD, tseq_pkg::R_D, tseq_pkg::R_NONE,
                               6'h00, 32'h1);
            8'h0a: uinst <= ui(tseq_pkg::OP_WRITE, tseq_pkg::R_NONE, tseq_pkg::R_NONE,
                               6'h00, 32'h0);
            // poll until idle
            8'h0b: uinst <= ui(tseq_pkg::OP_ADD, tseq_pkg::R_A, tseq_pkg::R_NONE,
                               6'h00, 32'(`TSEQ_REG_STATUS));
            8'h0c: uinst <= ui(tseq_pkg::OP_WAIT, tseq_pkg::R_NONE, tseq_pkg::R_NONE,
                               6'h00, 32'h0);
            8'h0d: uinst <= ui(tseq_pkg::OP_READ, tseq_pkg::R_NONE, tseq_pkg::R_NONE,
                               6'h00, 32'h0);
            8'h0e: uinst <= ui(tseq_pkg::OP_TST, tseq_pkg::R_D, tseq_pkg::R_I,
                               6'h0c, 32'h1);                     // busy, poll again
            // read back and compare
            8'h0f: uinst <= ui(tseq_pkg::OP_ADD, tseq_pkg::R_A, tseq_pkg::R_NONE,
                               6'h00, 32'(`TSEQ_MEM_BASE));
            8'h10: uinst <= ui(tseq_pkg::OP_ADD, tseq_pkg::R_B, tseq_pkg::R_NONE,
                               6'h00, 32'h0);
            8'h11: uinst <= ui(tseq_pkg::OP_READ, tseq_pkg::R_NONE, tseq_pkg::R_NONE,
                               6'h00, 32'h0);
            8'h12: uinst <= ui(tseq_pkg::OP_CMP, tseq_pkg::R_D, tseq_pkg::R_P,
                               6'h14, 32'h0);                     // match skips fault
            8'h13: uinst <= ui(tseq_pkg::OP_FAULT, tseq_pkg::R_NONE, tseq_pkg::R_NONE,
                               6'h00, 32'h0);
            8'h14: uinst <= ui(tseq_pkg::OP_ADD, tseq_pkg::R_A, tseq_pkg::R_A,
                               6'h00, 32'h4);
            8'h15: uinst <= ui(tseq_pkg::OP_ADD, tseq_pkg::R_B, tseq_pkg::R_B,
                               6'h00, 32'h1);
            8'h16: uinst <= ui(tseq_pkg::OP_CMP, tseq_pkg::R_B, tseq_pkg::R_I,
                               6'h18, 32'(`TSEQ_FILL_WORDS));
            8'h17: uinst <= ui(tseq_pkg::OP_JMP, tseq_pkg::R_NONE, tseq_pkg::R_NONE,
                               6'h11, 32'h0);
            8'h18: uinst <= ui(tseq_pkg::OP_DONE, tseq_pkg::R_NONE, tseq_pkg::R_NONE,
                               6'h00, 32'h0);
            default:
               uinst <= ui(tseq_pkg::OP_JMP, tseq_pkg::R_NONE, tseq_pkg::R_NONE,
                           6'h00, 32'h0);
         endcase
   end

endmodule

`default_nettype wire

//--- source/tseq_exec.sv
// ==============================
// execute stage: pc, stall, branch,
// registers, alu, pattern, wait, halt
// ==============================
`timescale 1ns/100ps
`default_nettype none
`include "tseq_defs.svh"

module tseq_exec (
   input  logic             clk,
   input  logic             reset,
   input  logic             start,
   input  tseq_pkg::uinst_t uinst,
   output tseq_pkg::uaddr_t fetch_addr,
   output tseq_pkg::uaddr_t pc,
   output logic             mem_req,
   output logic             mem_write,
   output tseq_pkg::paddr_t mem_addr,
   output tseq_pkg::word_t  mem_wdata,
   input  logic             mem_ack,
   input  tseq_pkg::word_t  mem_rdata,
   input  logic             mem_err,
   output logic             done,
   output logic             fault
);

   tseq_pkg::opcode_e  op;
   tseq_pkg::reg_sel_e dsel;
   tseq_pkg::reg_sel_e ssel;
   logic [5:0]         target;
   tseq_pkg::word_t    imm;
   tseq_pkg::word_t    reg_a;
   tseq_pkg::word_t    reg_b;
   tseq_pkg::word_t    reg_c;
   tseq_pkg::word_t    reg_d;
   tseq_pkg::word_t    pattern;
   tseq_pkg::word_t    src;
   tseq_pkg::word_t    dst;
   tseq_pkg::word_t    alu_res;
   tseq_pkg::uaddr_t   npc;
   logic [7:0]         wait_cnt;
   logic               wait_done;
   logic               is_bus;
   logic               is_alu;
   logic               halted;
   logic               ack_seen;
   logic               bus_ok;
   logic               take_branch;
   logic               stall;
   logic               advance;

   assign op     = tseq_pkg::opcode_e'(uinst[47:44]);
   assign dsel   = tseq_pkg::reg_sel_e'(uinst[43:41]);
   assign ssel   = tseq_pkg::reg_sel_e'(uinst[40:38]);
   assign target = uinst[37:32];
   assign imm    = uinst[31:0];

   assign pattern = {~reg_a[15:0], reg_a[15:0]};

   always_comb
   begin
      case (ssel)
         tseq_pkg::R_A: src = reg_a;
         tseq_pkg::R_B: src = reg_b;
         tseq_pkg::R_C: src = reg_c;
         tseq_pkg::R_D: src = reg_d;
         tseq_pkg::R_I: src = imm;
         tseq_pkg::R_P: src = pattern;
         default:       src = '0;
      endcase
   end

   always_comb
   begin
      case (dsel)
         tseq_pkg::R_A: dst = reg_a;
         tseq_pkg::R_B: dst = reg_b;
         tseq_pkg::R_C: dst = reg_c;
         tseq_pkg::R_D: dst = reg_d;
         default:       dst = '0;
      endcase
   end

   assign alu_res = (op == tseq_pkg::OP_SUB) ? src - imm : src + imm;
   assign is_alu  = (op == tseq_pkg::OP_ADD) || (op == tseq_pkg::OP_SUB);
   assign is_bus  = (op == tseq_pkg::OP_WRITE) || (op == tseq_pkg::OP_READ);

   assign take_branch = ((op == tseq_pkg::OP_TST) && ~|(dst & src)) ||
                        ((op == tseq_pkg::OP_CMP) && (dst == src)) ||
                        (op == tseq_pkg::OP_JMP);

   assign halted    = done | fault;
   assign bus_ok    = mem_ack | ack_seen;
   assign wait_done = wait_cnt == 8'(`TSEQ_WAIT_CYCLES - 1);

   assign stall = ~start || halted ||
                  (op == tseq_pkg::OP_DONE) || (op == tseq_pkg::OP_FAULT) ||
                  ((op == tseq_pkg::OP_WAIT) && ~wait_done) ||
                  (is_bus && ~bus_ok) ||
                  (mem_ack && mem_err);   // hold on the failing transfer
   assign advance = ~stall;

   assign npc        = take_branch ? {2'b00, target} : pc + 8'd1;
   assign fetch_addr = stall ? pc : npc;   // replay current word when stalled

   assign mem_req   = is_bus && start && ~halted && ~ack_seen;
   assign mem_write = op == tseq_pkg::OP_WRITE;
   assign mem_addr  = reg_a[15:0];
   assign mem_wdata = reg_d;

   always_ff @(posedge clk)
   begin
      if (reset)
         pc <= '1;   // first fetch wraps to 0
      else if (advance)
         pc <= npc;
   end

   // ack that landed while start was low
   always_ff @(posedge clk)
   begin
      if (reset)
         ack_seen <= 1'b0;
      else if (advance)
         ack_seen <= 1'b0;
      else if (mem_ack)
         ack_seen <= 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         wait_cnt <= '0;
      else if (advance)
         wait_cnt <= '0;
      else if ((op == tseq_pkg::OP_WAIT) && ~wait_done)
         wait_cnt <= wait_cnt + 8'd1;
   end

   always_ff @(posedge clk)
   begin
      if (advance && is_alu)
         case (dsel)
            tseq_pkg::R_A: reg_a <= alu_res;
            tseq_pkg::R_B: reg_b <= alu_res;
            tseq_pkg::R_C: reg_c <= alu_res;
            default: ;
         endcase
      if (mem_ack && (op == tseq_pkg::OP_READ))
         reg_d <= mem_rdata;
      else if (advance && is_alu && (dsel == tseq_pkg::R_D))
         reg_d <= alu_res;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         done  <= 1'b0;
         fault <= 1'b0;
      end
      else
      begin
         if (start && ~halted && (op == tseq_pkg::OP_DONE))
            done <= 1'b1;
         if ((start && ~halted && (op == tseq_pkg::OP_FAULT)) || (mem_ack && mem_err))
            fault <= 1'b1;   // sticky until reset
      end
   end

endmodule

`default_nettype wire

//--- source/tseq_apb_master.sv
// ==============================
// APB master, one transfer per request
// ==============================
`timescale 1ns/100ps
`default_nettype none

module tseq_apb_master (
   input  logic             clk,
   input  logic             reset,
   input  logic             mem_req,
   input  logic             mem_write,
   input  tseq_pkg::paddr_t mem_addr,
   input  tseq_pkg::word_t  mem_wdata,
   output logic             mem_ack,
   output tseq_pkg::word_t  mem_rdata,
   output logic             mem_err,
   output logic             psel,
   output logic             penable,
   output logic             pwrite,
   output tseq_pkg::paddr_t paddr,
   output tseq_pkg::word_t  pwdata,
   input  tseq_pkg::word_t  prdata,
   input  logic             pready,
   input  logic             pslverr
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_SETUP,
      ST_ACCESS
   } apb_state_e;

   apb_state_e state;

   always_ff @(posedge clk)
   begin
      if (reset)
         state <= ST_IDLE;
      else
         case (state)
            ST_IDLE:
               if (mem_req)
                  state <= ST_SETUP;
            ST_SETUP:
               state <= ST_ACCESS;
            ST_ACCESS:
               if (pready)
                  state <= ST_IDLE;   // wait states just hold here
            default:
               state <= ST_IDLE;
         endcase
   end

   // address phase captured once, stable to the end
   always_ff @(posedge clk)
   begin
      if ((state == ST_IDLE) && mem_req)
      begin
         paddr  <= mem_addr;
         pwrite <= mem_write;
         pwdata <= mem_wdata;
      end
   end

   assign psel    = state != ST_IDLE;
   assign penable = state == ST_ACCESS;

   assign mem_ack   = (state == ST_ACCESS) && pready;
   assign mem_rdata = prdata;
   assign mem_err   = mem_ack && pslverr;

endmodule

`default_nettype wire

//--- source/tseq_top.sv
// ==============================
// sequencer top: rom fetch, execute
// and APB master
// ==============================
`timescale 1ns/100ps
`default_nettype none

module tseq_top (
   input  logic             clk,
   input  logic             reset,
   input  logic             start,
   output logic             done,
   output logic             fault,
   output tseq_pkg::uaddr_t pc,
   output logic             psel,
   output logic             penable,
   output logic             pwrite,
   output tseq_pkg::paddr_t paddr,
   output tseq_pkg::word_t  pwdata,
   input  tseq_pkg::word_t  prdata,
   input  logic             pready,
   input  logic             pslverr
);

   tseq_pkg::uaddr_t fetch_addr;
   tseq_pkg::uinst_t uinst;
   logic             mem_req;
   logic             mem_write;
   tseq_pkg::paddr_t mem_addr;
   tseq_pkg::word_t  mem_wdata;
   logic             mem_ack;
   tseq_pkg::word_t  mem_rdata;
   logic             mem_err;

   tseq_urom u_urom (
      .clk        (clk),
      .reset      (reset),
      .fetch_addr (fetch_addr),
      .uinst      (uinst)
   );

   tseq_exec u_exec (
      .clk        (clk),
      .reset      (reset),
      .start      (start),
      .uinst      (uinst),
      .fetch_addr (fetch_addr),
      .pc         (pc),
      .mem_req    (mem_req),
      .mem_write  (mem_write),
      .mem_addr   (mem_addr),
      .mem_wdata  (mem_wdata),
      .mem_ack    (mem_ack),
      .mem_rdata  (mem_rdata),
      .mem_err    (mem_err),
      .done       (done),
      .fault      (fault)
   );

   tseq_apb_master u_apb (
      .clk       (clk),
      .reset     (reset),
      .mem_req   (mem_req),
      .mem_write (mem_write),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_ack   (mem_ack),
      .mem_rdata (mem_rdata),
      .mem_err   (mem_err),
      .psel      (psel),
      .penable   (penable),
      .pwrite    (pwrite),
      .paddr     (paddr),
      .pwdata    (pwdata),
      .prdata    (prdata),
      .pready    (pready),
      .pslverr   (pslverr)
   );

endmodule

`default_nettype wire

//--- dv/apb_mem_model.sv
// ==============================
// behavioral APB peripheral: memory
// window, GO / STATUS registers, wait
// states, busy time, fault injection
// ==============================
`timescale 1ns/100ps
`default_nettype none
`include "tseq_defs.svh"

module apb_mem_model (
   input  logic             clk,
   input  logic             reset,
   input  logic             psel,
   input  logic             penable,
   input  logic             pwrite,
   input  tseq_pkg::paddr_t paddr,
   input  tseq_pkg::word_t  pwdata,
   output tseq_pkg::word_t  prdata,
   output logic             pready,
   output logic             pslverr,
   input  logic             corrupt_en,
   input  tseq_pkg::paddr_t corrupt_addr,
   input  logic             err_en,
   input  tseq_pkg::paddr_t err_addr
);

   tseq_pkg::word_t  mem [`TSEQ_FILL_WORDS];
   tseq_pkg::paddr_t offs;
   int               idx;
   logic             in_window;
   logic [1:0]       wait_left;
   int unsigned      busy_cnt;

   assign offs      = paddr - 16'(`TSEQ_MEM_BASE);
   assign idx       = int'(offs[15:2]);
   assign in_window = (paddr >= 16'(`TSEQ_MEM_BASE)) && (idx < `TSEQ_FILL_WORDS);

   always_comb
   begin
      if (paddr == 16'(`TSEQ_REG_STATUS))
         prdata = {31'b0, busy_cnt == 0};   // idle bit
      else if (in_window)
         prdata = mem[idx];
      else
         prdata = '0;
   end

   assign pready  = psel && penable && (wait_left == 2'd0);
   assign pslverr = pready && err_en && !pwrite && (paddr == err_addr);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         wait_left <= 2'd0;
         busy_cnt  <= 0;
         for (int i = 0; i < `TSEQ_FILL_WORDS; i++)
            mem[i] <= {16'(`TSEQ_MEM_BASE + 4 * i), 16'(`TSEQ_MEM_BASE + 4 * i)} ^ 32'h5a5a0000;
      end
      else
      begin
         if (psel && !penable)
            wait_left <= 2'($urandom_range(0, 3));   // per transfer
         else if (psel && penable && (wait_left != 2'd0))
            wait_left <= wait_left - 2'd1;
         if (busy_cnt != 0)
            busy_cnt <= busy_cnt - 1;
         if (pready && pwrite)
         begin
            if (paddr == 16'(`TSEQ_REG_GO))
               busy_cnt <= $urandom_range(20, 200);
            else if (in_window)
               mem[idx] <= (corrupt_en && (paddr == corrupt_addr)) ? pwdata ^ 32'h00000100
                                                                   : pwdata;
         end
      end
   end

endmodule

`default_nettype wire

//--- dv/tseq_tb.sv
// ==============================
// testbench with clock, reset, three runs,
// APB assertions, result checks, summary
// ==============================
`timescale 1ns/100ps
`default_nettype none
`include "tseq_defs.svh"

module tseq_tb;

   localparam int RUN_LIMIT    = 20000;   // 130 transfers x 6, polls, busy time, margin
   localparam int SETTLE       = 20;
   localparam int MODE_CLEAN   = 0;
   localparam int MODE_CORRUPT = 1;
   localparam int MODE_SLVERR  = 2;

   logic             clk;
   logic             reset;
   logic             start;
   logic             done;
   logic             fault;
   tseq_pkg::uaddr_t pc;
   logic             psel;
   logic             penable;
   logic             pwrite;
   tseq_pkg::paddr_t paddr;
   tseq_pkg::word_t  pwdata;
   tseq_pkg::word_t  prdata;
   logic             pready;
   logic             pslverr;
   logic             corrupt_en;
   logic             err_en;
   tseq_pkg::paddr_t corrupt_addr;
   tseq_pkg::paddr_t err_addr;

   int               errors;
   int               timeouts;
   int               transfers;
   int               runs;
   int               mode;
   int               fill_count;
   int               read_count;
   int               last_status;
   int               cycle;
   bit               go_seen;
   bit               idle_seen;
   bit               err_pending;
   bit               halt_seen;
   tseq_pkg::uaddr_t halt_pc;
   tseq_pkg::uaddr_t last_pc;
   logic             last_start;
   logic             last_psel;

   tseq_top u_dut (
      .clk     (clk),
      .reset   (reset),
      .start   (start),
      .done    (done),
      .fault   (fault),
      .pc      (pc),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr)
   );

   apb_mem_model u_mem (
      .clk          (clk),
      .reset        (reset),
      .psel         (psel),
      .penable      (penable),
      .pwrite       (pwrite),
      .paddr        (paddr),
      .pwdata       (pwdata),
      .prdata       (prdata),
      .pready       (pready),
      .pslverr      (pslverr),
      .corrupt_en   (corrupt_en),
      .corrupt_addr (corrupt_addr),
      .err_en       (err_en),
      .err_addr     (err_addr)
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic report_error(input string msg);
      errors++;
      $display("ERR %0t: %s", $time, msg);
   endtask

   // inverted low half of the address on top, low half below
   function automatic tseq_pkg::word_t expected_word(input tseq_pkg::paddr_t a);
      return {~a, a};
   endfunction

   function automatic tseq_pkg::paddr_t window_addr(input int n);
      return 16'(`TSEQ_MEM_BASE + 4 * n);
   endfunction

   assert property (@(posedge clk) disable iff (reset) penable |-> psel)
      else report_error("penable high without psel");
   assert property (@(posedge clk) disable iff (reset) $rose(psel) |-> !penable)
      else report_error("transfer started without a setup cycle");
   assert property (@(posedge clk) disable iff (reset) psel && penable && pready |=> !penable)
      else report_error("access not followed by idle or setup");
   assert property (@(posedge clk) disable iff (reset)
                    psel && !(penable && pready) |=>
                    psel && $stable(paddr) && $stable(pwrite) && $stable(pwdata))
      else report_error("APB address, direction or data changed before pready");
   assert property (@(posedge clk) $fell(reset) |-> !psel && !penable && !done && !fault)
      else report_error("psel, penable, done or fault high after reset");

   task automatic check_transfer();
      transfers++;
      if (pslverr)
         err_pending = 1'b1;
      if (pwrite && (paddr == 16'(`TSEQ_REG_GO)))
      begin
         assert (fill_count == `TSEQ_FILL_WORDS)
            else report_error($sformatf("GO after %0d fill writes", fill_count));
         go_seen = 1'b1;
      end
      else if (pwrite)
      begin
         assert (!go_seen && (paddr == window_addr(fill_count)))
            else report_error($sformatf("fill write at %h, expected %h",
                                        paddr, window_addr(fill_count)));
         assert (pwdata == expected_word(paddr))
            else report_error($sformatf("fill data %h at %h, expected %h",
                                        pwdata, paddr, expected_word(paddr)));
         fill_count++;
      end
      else if (paddr == 16'(`TSEQ_REG_STATUS))
      begin
         assert ((last_status < 0) || (cycle - last_status >= `TSEQ_WAIT_CYCLES))
            else report_error($sformatf("STATUS polls %0d cycles apart", cycle - last_status));
         last_status = cycle;
         if (prdata[0])
            idle_seen = 1'b1;
      end
      else
      begin
         assert (idle_seen && (paddr == window_addr(read_count)))
            else report_error($sformatf("readback at %h, idle %0b, expected %h",
                                        paddr, idle_seen, window_addr(read_count)));
         if (mode == MODE_CORRUPT)
         begin
            assert (paddr <= corrupt_addr)
               else report_error($sformatf("read at %h past corrupted %h", paddr, corrupt_addr));
         end
         read_count++;
      end
   endtask

   // bus and pc monitor
   always @(posedge clk)
   begin
      if (reset)
      begin
         fill_count  = 0;
         read_count  = 0;
         last_status = -1;
         cycle       = 0;
         go_seen     = 1'b0;
         idle_seen   = 1'b0;
         err_pending = 1'b0;
         halt_seen   = 1'b0;
         last_start  = 1'b1;
      end
      else
      begin
         if (!last_start)
         begin
            assert (pc == last_pc)
               else report_error($sformatf("pc %h moved from %h with start low", pc, last_pc));
            assert (!(psel && !last_psel))
               else report_error("transfer began with start low");
         end
         if (err_pending)
         begin
            assert (fault)
               else report_error("fault not raised after pslverr");
         end
         err_pending = 1'b0;
         if (done || fault)
         begin
            if (!halt_seen)
               halt_pc = pc;
            halt_seen = 1'b1;
            assert (!psel && (pc == halt_pc))
               else report_error($sformatf("pc %h psel %0b after halt", pc, psel));
         end
         if (psel && penable && pready)
            check_transfer();
         cycle++;
      end
      last_pc   = pc;
      last_psel = psel;
      if (!reset)
         last_start = start;
   end

   task automatic do_run(input int run_mode);
      int cycles;
      int gate_at;
      int gate_len;
      int idx;
      idx          = $urandom_range(0, `TSEQ_FILL_WORDS - 1);
      gate_at      = (run_mode == MODE_CLEAN) ? $urandom_range(50, 600) : RUN_LIMIT + 1;
      gate_len     = $urandom_range(20, 200);
      mode         = run_mode;
      corrupt_en   = run_mode == MODE_CORRUPT;
      err_en       = run_mode == MODE_SLVERR;
      corrupt_addr = window_addr(idx);
      err_addr     = window_addr(idx);
      reset        = 1'b1;
      repeat (3) @(posedge clk);
      #1 reset = 1'b0;
      cycles = 0;
      while (!(done || fault) && (cycles < RUN_LIMIT))
      begin
         @(posedge clk);
         #1;
         cycles++;
         if (cycles == gate_at)
            start = 1'b0;   // pause mid-run
         if (cycles == gate_at + gate_len)
            start = 1'b1;
      end
      if (cycles >= RUN_LIMIT)
      begin
         $display("timeout: run %0d reached neither done nor fault in %0d cycles",
                  runs, RUN_LIMIT);
         timeouts++;
      end
      else
      begin
         repeat (SETTLE) @(posedge clk);
         #1;
         assert (go_seen && (fill_count == `TSEQ_FILL_WORDS))
            else report_error($sformatf("run %0d filled %0d words", runs, fill_count));
         if (run_mode == MODE_CLEAN)
         begin
            assert (done && !fault && (read_count == `TSEQ_FILL_WORDS))
               else report_error($sformatf("clean run: done %0b fault %0b reads %0d",
                                           done, fault, read_count));
         end
         else
         begin
            assert (fault && !done && (read_count == idx + 1))
               else report_error($sformatf("run %0d: done %0b fault %0b reads %0d, expected %0d",
                                           runs, done, fault, read_count, idx + 1));
         end
      end
      start = 1'b1;
      runs++;
   endtask

   initial
   begin
      void'($urandom(66019));
      errors       = 0;
      timeouts     = 0;
      transfers    = 0;
      runs         = 0;
      mode         = MODE_CLEAN;
      reset        = 1'b1;
      start        = 1'b1;
      corrupt_en   = 1'b0;
      err_en       = 1'b0;
      corrupt_addr = '0;
      err_addr     = '0;
      do_run(MODE_CLEAN);
      if (timeouts == 0)
         do_run(MODE_CORRUPT);
      if (timeouts == 0)
         do_run(MODE_SLVERR);
      $display("summary: %0d runs, %0d transfers, %0d errors, %0d timeouts",
               runs, transfers, errors, timeouts);
      if ((errors == 0) && (timeouts == 0))
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- sim.f
+incdir+include
source/tseq_pkg.sv
source/tseq_urom.sv
source/tseq_exec.sv
source/tseq_apb_master.sv
source/tseq_top.sv
dv/apb_mem_model.sv
dv/tseq_tb.sv

//--- Bender.yml
package:
  name: tseq

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/tseq_pkg.sv
      - source/tseq_urom.sv
      - source/tseq_exec.sv
      - source/tseq_apb_master.sv
      - source/tseq_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/apb_mem_model.sv
      - dv/tseq_tb.sv
